// ==== filelist.f ====
src/spi_periph_pkg.sv
src/spi_sampler.sv
src/spi_bit_counter.sv
src/spi_frame_fsm.sv
src/reg_bank.sv
src/cs_router.sv
src/led_driver.sv
src/spi_periph_top.sv
verif/spi_periph_props.sv
verif/tb_spi_periph.sv

// ==== Makefile ====
TOP := tb_spi_periph
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): filelist.f src/*.sv verif/*.sv
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG) || (echo "simulation did not complete"; exit 1)

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)
	verilator --lint-only src/spi_periph_pkg.sv src/spi_sampler.sv src/spi_bit_counter.sv \
		src/spi_frame_fsm.sv src/reg_bank.sv src/cs_router.sv src/led_driver.sv \
		src/spi_periph_top.sv --top-module spi_periph_top

clean:
	rm -rf obj_dir $(LOG)

// ==== verif/tb_spi_periph.sv ====
// spi peripheral testbench
module tb_spi_periph
  import spi_periph_pkg::*;
;

  logic       clk;
  logic       rst_n;
  logic       sclk;
  logic       cs_n;
  logic       mosi;
  logic       special;
  logic [1:0] leds;
  logic       adc_cs_n;
  logic       aux_cs_n;
  logic       frame_err;

  // stimulus table with one row per frame
  int         row_bits [16];
  logic       row_spec [16];
  addr_t      row_addr [16];
  data_t      row_data [16];
  logic [1:0] row_leds [16];
  logic       row_adc  [16];
  logic       row_aux  [16];
  logic       row_err  [16];
  int         n_rows;

  // register model used while building rows
  data_t       model_led;
  route_t      model_route;
  logic [31:0] lcg_state;
  // cs levels expected in the next window
  logic        prev_adc;
  logic        prev_aux;
  int          checks;
  int          errors;

  spi_periph_top #(
    .BLINK_BITS (4)
  ) DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .special   (special),
    .leds      (leds),
    .adc_cs_n  (adc_cs_n),
    .aux_cs_n  (aux_cs_n),
    .frame_err (frame_err)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // led data with bit 7 kept clear for static mode
  function automatic data_t next_led_data();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {1'b0, lcg_state[30:24]};
  endfunction

  // led data whose low bits differ from the current model
  function automatic data_t led_data_unlike_model();
    data_t d;
    d = next_led_data();
    if (d[1:0] == model_led[1:0])
      d[1:0] = ~d[1:0];
    return d;
  endfunction

  // row plus expected outputs from the decode rules
  task automatic add_row(input int nbits, input logic spec, input addr_t addr, input data_t data);
    logic commit;
    commit = (nbits == 16) && !spec
             && (addr == addr_led || addr == addr_route || addr == addr_blink);
    if (commit && addr == addr_led)
      model_led = data;
    if (commit && addr == addr_route)
      model_route = route_t'(data);
    row_bits[n_rows] = nbits;
    row_spec[n_rows] = spec;
    row_addr[n_rows] = addr;
    row_data[n_rows] = data;
    row_leds[n_rows] = model_led[1:0];
    // live cs low reaches only the routed device
    row_adc[n_rows]  = (model_route == route_adc) ? 1'b0 : 1'b1;
    row_aux[n_rows]  = (model_route == route_aux) ? 1'b0 : 1'b1;
    row_err[n_rows]  = (nbits != 16);
    n_rows++;
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_err(input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Error: frame_err got 0x%0h expected 0x%0h", got, exp);
    end
  endtask

  // mode 0 frame with 4 clk per sclk phase
  // cs levels sampled mid window
  task automatic send_frame(input int nbits, input logic spec, input addr_t addr,
                            input data_t data, output logic seen_adc, output logic seen_aux);
    logic [16:0] word;
    logic [4:0]  idx;
    word    = {1'b0, addr, data};
    special = spec;
    sclk    = 1'b0;
    cs_n    = 1'b0;
    repeat (2) @(negedge clk);
    seen_adc = adc_cs_n;
    seen_aux = aux_cs_n;
    repeat (2) @(negedge clk);
    for (int i = nbits; i > 0; i--)
    begin
      idx  = 5'(i - 1);
      mosi = word[idx];
      repeat (4) @(negedge clk);
      sclk = 1'b1;
      repeat (4) @(negedge clk);
      sclk = 1'b0;
    end
    repeat (4) @(negedge clk);
    cs_n = 1'b1;
    mosi = 1'b0;
  endtask

  // 10 cycle window after cs release
  task automatic watch_err(output logic seen);
    seen = 1'b0;
    for (int c = 0; c < 10; c++)
    begin
      @(negedge clk);
      if (frame_err)
        seen = 1'b1;
    end
  endtask

  task automatic apply_row(input int i);
    logic seen_adc;
    logic seen_aux;
    logic seen_err;
    send_frame(row_bits[i], row_spec[i], row_addr[i], row_data[i], seen_adc, seen_aux);
    check_bit("adc_cs_n", seen_adc, prev_adc);
    check_bit("aux_cs_n", seen_aux, prev_aux);
    watch_err(seen_err);
    special = 1'b0;
    check_err(seen_err, row_err[i]);
    check_data("leds", data_t'(leds), data_t'(row_leds[i]));
    // both idle with cs_n high
    check_bit("adc_cs_n", adc_cs_n, 1'b1);
    check_bit("aux_cs_n", aux_cs_n, 1'b1);
    prev_adc = row_adc[i];
    prev_aux = row_aux[i];
  endtask

  // gray pattern steps one bit at a time
  task automatic check_blink();
    logic [1:0] last;
    int         changes;
    last    = leds;
    changes = 0;
    for (int c = 0; c < 200; c++)
    begin
      @(negedge clk);
      if (leds !== last)
      begin
        changes++;
        checks++;
        if ($countones(leds ^ last) != 1)
        begin
          errors++;
          $display("blink step from %0h to %0h changed more than one led", last, leds);
        end
        last = leds;
      end
    end
    checks++;
    if (changes == 0)
    begin
      errors++;
      $display("leds never changed in blink mode");
    end
  endtask

  initial
  begin
    logic seen_adc;
    logic seen_aux;
    logic seen_err;
    checks      = 0;
    errors      = 0;
    n_rows      = 0;
    model_led   = '0;
    model_route = '0;
    lcg_state   = 32'd93;
    rst_n       = 1'b0;
    sclk        = 1'b0;
    cs_n        = 1'b1;
    mosi        = 1'b0;
    special     = 1'b0;
    add_row(16, 1'b0, addr_led, next_led_data());
    add_row(16, 1'b0, addr_led, next_led_data());
    add_row(16, 1'b0, addr_route, 8'd1);
    add_row(16, 1'b0, addr_led, next_led_data());
    add_row(16, 1'b0, addr_route, 8'd2);
    add_row(16, 1'b0, addr_led, next_led_data());
    // an even route value lets a short next frame decode as an led write
    add_row(16, 1'b0, addr_route, 8'd4);
    // wrong lengths
    add_row(15, 1'b0, addr_led, led_data_unlike_model());
    add_row(17, 1'b0, addr_led, led_data_unlike_model());
    // special and unknown address frames are dropped
    add_row(16, 1'b1, addr_led, led_data_unlike_model());
    add_row(16, 1'b1, addr_route, 8'd1);
    add_row(16, 1'b0, 8'h33, 8'h01);
    add_row(16, 1'b0, addr_route, 8'd1);
    add_row(16, 1'b0, addr_blink, 8'd1);
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    // idle outputs after reset
    watch_err(seen_err);
    check_err(seen_err, 1'b0);
    check_data("leds", data_t'(leds), 8'h00);
    check_bit("adc_cs_n", adc_cs_n, 1'b1);
    check_bit("aux_cs_n", aux_cs_n, 1'b1);
    prev_adc = 1'b1;
    prev_aux = 1'b1;
    for (int i = 0; i < n_rows; i++)
      apply_row(i);
    // blink on while probing the last route
    send_frame(16, 1'b0, addr_led, 8'h80, seen_adc, seen_aux);
    check_bit("adc_cs_n", seen_adc, prev_adc);
    check_bit("aux_cs_n", seen_aux, prev_aux);
    watch_err(seen_err);
    check_err(seen_err, 1'b0);
    check_blink();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  // hang guard
  initial
  begin
    for (int c = 0; c < 20000; c++)
      @(posedge clk);
    $display("simulation timed out before the test finished");
    $display("** FAIL **");
    $finish;
  end

endmodule

// ==== verif/spi_periph_props.sv ====
// spi peripheral properties
module spi_periph_props
(
  input logic clk,
  input logic rst_n,
  input logic adc_cs_n,
  input logic aux_cs_n,
  input logic frame_err
);

  // one downstream device at a time
  a_cs_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(!adc_cs_n && !aux_cs_n))
    else $error("adc_cs_n and aux_cs_n both low");

  // error is a pulse, never a level
  a_err_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    frame_err |=> !frame_err)
    else $error("frame_err high for more than one cycle");

  // route cleared in reset
  a_cs_reset: assert property (@(posedge clk)
    !rst_n |-> (adc_cs_n && aux_cs_n))
    else $error("chip select low during reset");

endmodule

bind spi_periph_top spi_periph_props u_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .adc_cs_n  (adc_cs_n),
  .aux_cs_n  (aux_cs_n),
  .frame_err (frame_err)
);

// ==== src/spi_periph_top.sv ====
// spi peripheral controller top
module spi_periph_top
  import spi_periph_pkg::*;
#(
  parameter int BLINK_BITS = 19
)
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sclk,
  input  logic       cs_n,
  input  logic       mosi,
  input  logic       special,
  output logic [1:0] leds,
  output logic       adc_cs_n,
  output logic       aux_cs_n,
  output logic       frame_err
);

  // sampler outputs
  logic   sclk_rise;
  logic   cs_fall;
  logic   cs_rise;
  logic   special_s;
  frame_t frame;

  // frame control
  logic count_clr;
  logic len_ok;
  logic wr_en;

  // register contents
  data_t  led_reg;
  route_t route;
  data_t  blink_rate;

  spi_sampler u_sampler (
    .clk       (clk),
    .rst_n     (rst_n),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .special   (special),
    .sclk_rise (sclk_rise),
    .cs_fall   (cs_fall),
    .cs_rise   (cs_rise),
    .special_s (special_s),
    .frame     (frame)
  );

  spi_bit_counter u_bit_counter (
    .clk       (clk),
    .rst_n     (rst_n),
    .count_clr (count_clr),
    .sclk_rise (sclk_rise),
    .len_ok    (len_ok)
  );

  spi_frame_fsm u_frame_fsm (
    .clk       (clk),
    .rst_n     (rst_n),
    .cs_fall   (cs_fall),
    .cs_rise   (cs_rise),
    .len_ok    (len_ok),
    .special_s (special_s),
    .count_clr (count_clr),
    .wr_en     (wr_en),
    .frame_err (frame_err)
  );

  reg_bank u_reg_bank (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_en      (wr_en),
    .frame      (frame),
    .led_reg    (led_reg),
    .route      (route),
    .blink_rate (blink_rate)
  );

  // the router passes the live cs_n pin
  cs_router u_cs_router (
    .cs_n     (cs_n),
    .route    (route),
    .adc_cs_n (adc_cs_n),
    .aux_cs_n (aux_cs_n)
  );

  led_driver #(
    .BLINK_BITS (BLINK_BITS)
  ) u_led_driver (
    .clk        (clk),
    .rst_n      (rst_n),
    .led_reg    (led_reg),
    .blink_rate (blink_rate),
    .leds       (leds)
  );

endmodule

// ==== src/led_driver.sv ====
// led blink and select driver
module led_driver
  import spi_periph_pkg::*;
#(
  parameter int BLINK_BITS = 19
)
(
  input  logic       clk,
  input  logic       rst_n,
  input  data_t      led_reg,
  input  data_t      blink_rate,
  output logic [1:0] leds
);

  // extra low bits for the rate shift, blink_rate[1:0] picks up to 3
  localparam int rate_max = 3;
  localparam int cnt_w    = BLINK_BITS + 2 + rate_max;

  logic [cnt_w-1:0] blink_cnt;
  logic [1:0]       tap;
  logic [1:0]       gray;

  // free running
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      blink_cnt <= '0;
    else
      blink_cnt <= blink_cnt + 1'b1;
  end

  // top pair of the selected window, higher rate means slower
  assign tap  = blink_cnt[BLINK_BITS + int'(blink_rate[1:0]) +: 2];
  assign gray = tap ^ (tap >> 1);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      leds <= 2'b00;
    // bit 7 selects blink mode
    else if (led_reg[7])
      leds <= gray;
    else
      leds <= led_reg[1:0];
  end

endmodule

// ==== src/cs_router.sv ====
// downstream chip select router
module cs_router
  import spi_periph_pkg::*;
(
  input  logic   cs_n,
  input  route_t route,
  output logic   adc_cs_n,
  output logic   aux_cs_n
);

  // live cs line passes straight through
  always_comb
  begin
    // both deasserted unless a device is selected
    adc_cs_n = 1'b1;
    aux_cs_n = 1'b1;
    case (route)
      route_adc:
      begin
        adc_cs_n = cs_n;
      end
      route_aux:
      begin
        aux_cs_n = cs_n;
      end
      default:
      begin
        // any other route leaves both high
      end
    endcase
  end

endmodule

// ==== src/reg_bank.sv ====
// peripheral register bank
module reg_bank
  import spi_periph_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   wr_en,
  input  frame_t frame,
  output data_t  led_reg,
  output route_t route,
  output data_t  blink_rate
);

  // high byte holds the address and low byte the data
  addr_t wr_addr;
  data_t wr_data;

  assign wr_addr = frame[15:8];
  assign wr_data = frame[7:0];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      led_reg    <= '0;
      route      <= '0;
      blink_rate <= '0;
    end
    else if (wr_en)
    begin
      case (wr_addr)
        addr_led:
        begin
          led_reg <= wr_data;
        end
        addr_route:
        begin
          // written only while cs_n is high so the router sees no glitch
          route <= route_t'(wr_data);
        end
        addr_blink:
        begin
          blink_rate <= wr_data;
        end
        default:
        begin
          // unknown address is ignored
        end
      endcase
    end
  end

endmodule

// ==== src/spi_frame_fsm.sv ====
// spi frame control FSM
module spi_frame_fsm
  import spi_periph_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic cs_fall,
  input  logic cs_rise,
  input  logic len_ok,
  input  logic special_s,
  output logic count_clr,
  output logic wr_en,
  output logic frame_err
);

  frame_state_t state;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= st_idle;
      count_clr <= 1'b0;
      wr_en     <= 1'b0;
      frame_err <= 1'b0;
    end
    else
    begin
      // pulse outputs drop back unless set below
      count_clr <= 1'b0;
      wr_en     <= 1'b0;
      frame_err <= 1'b0;
      case (state)
        st_idle:
        begin
          // new chip select window
          if (cs_fall)
          begin
            count_clr <= 1'b1;
            state     <= st_shift;
          end
        end
        st_shift:
        begin
          // bits arrive in the sampler meanwhile
          if (cs_rise)
            state <= st_check;
        end
        st_check:
        begin
          // length first, then the special flag
          if (!len_ok)
          begin
            frame_err <= 1'b1;
            state     <= st_idle;
          end
          else if (special_s)
            state <= st_idle;
          else
          begin
            wr_en <= 1'b1;
            state <= st_commit;
          end
        end
        st_commit:
        begin
          // wr_en is high for this one cycle
          state <= st_idle;
        end
        default:
        begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

// ==== src/spi_bit_counter.sv ====
// spi frame bit counter
module spi_bit_counter
  import spi_periph_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic count_clr,
  input  logic sclk_rise,
  output logic len_ok
);

  bit_cnt_t bit_cnt;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (count_clr)
      bit_cnt <= '0;
    // saturate, a long frame must never wrap back to 16
    else if (sclk_rise && (bit_cnt != '1))
      bit_cnt <= bit_cnt + 1'b1;
  end

  // exact length only
  assign len_ok = (bit_cnt == frame_bits);

endmodule

// ==== src/spi_sampler.sv ====
// spi pin sampler and shifter
module spi_sampler
  import spi_periph_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   sclk,
  input  logic   cs_n,
  input  logic   mosi,
  input  logic   special,
  output logic   sclk_rise,
  output logic   cs_fall,
  output logic   cs_rise,
  output logic   special_s,
  output frame_t frame
);

  // two stage synchronizers, index 1 is the safe one
  logic [1:0] sclk_sync;
  logic [1:0] cs_sync;
  logic [1:0] mosi_sync;
  logic [1:0] special_sync;

  // history flops for edge detect
  logic sclk_q;
  logic cs_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      // cs idles high so no false fall after reset
      sclk_sync    <= 2'b00;
      cs_sync      <= 2'b11;
      mosi_sync    <= 2'b00;
      special_sync <= 2'b00;
      sclk_q       <= 1'b0;
      cs_q         <= 1'b1;
    end
    else
    begin
      sclk_sync    <= {sclk_sync[0], sclk};
      cs_sync      <= {cs_sync[0], cs_n};
      mosi_sync    <= {mosi_sync[0], mosi};
      special_sync <= {special_sync[0], special};
      sclk_q       <= sclk_sync[1];
      cs_q         <= cs_sync[1];
    end
  end

  // single cycle edge pulses
  assign sclk_rise = sclk_sync[1] & ~sclk_q;
  assign cs_fall   = ~cs_sync[1] & cs_q;
  assign cs_rise   = cs_sync[1] & ~cs_q;
  assign special_s = special_sync[1];

  // mode 0, msb first
  // mosi sync delay matches sclk so the bit is stable at the rise
  always_ff @(posedge clk)
  begin
    if (sclk_rise && !cs_sync[1])
      frame <= {frame[$bits(frame_t)-2:0], mosi_sync[1]};
  end

endmodule

// ==== src/spi_periph_pkg.sv ====
// spi peripheral shared types
package spi_periph_pkg;

  // register address and data bytes
  typedef logic [7:0] addr_t;
  typedef logic [7:0] data_t;

  // whole shifted frame, address byte on top
  typedef logic [15:0] frame_t;

  // bit count, saturates at 31
  typedef logic [4:0] bit_cnt_t;

  // chip select route register contents
  typedef logic [7:0] route_t;

  // exact frame length
  localparam bit_cnt_t frame_bits = 5'd16;

  // known register addresses
  localparam addr_t addr_led   = 8'h07;
  localparam addr_t addr_route = 8'h01;
  localparam addr_t addr_blink = 8'h02;

  // route values that select a downstream device
  localparam route_t route_adc = 8'd1;
  localparam route_t route_aux = 8'd2;

  // frame control states
  typedef enum logic [1:0] {
    st_idle,
    st_shift,
    st_check,
    st_commit
  } frame_state_t;

endpackage
